//--- src/wb_pkg.sv
// ****************************************
// Shared types for the tagged-issue core
// Holds the opcode and unit enums and the
// packed structs that travel between the
// issue, queue, unit and writeback blocks
// ****************************************
`default_nettype none

package wb_pkg;

    // Sequence ids wrap modulo 16
    localparam int ID_W = 4;

    // Structs are sized for the widest data path; modules use XLEN bits of it
    localparam int XLEN_MAX = 32;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_MUL = 2'd3
    } op_t;

    // One bit is enough for the two peer units
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_t;

    // Instruction as it arrives on the four-phase port
    typedef struct packed {
        op_t                 op;
        logic [4:0]          rd_addr;
        logic [XLEN_MAX-1:0] a;
        logic [XLEN_MAX-1:0] b;
    } issue_req_t;

    // Operation handed to an execution unit together with its id
    typedef struct packed {
        op_t                 op;
        logic [ID_W-1:0]     id;
        logic [XLEN_MAX-1:0] a;
        logic [XLEN_MAX-1:0] b;
    } unit_start_t;

    // Queue entry, ten bits
    typedef struct packed {
        logic [ID_W-1:0] id;
        unit_t           unit;
        logic [4:0]      rd_addr;
    } iq_entry_t;

    // Retired instruction for the register write and the completion port
    typedef struct packed {
        logic [ID_W-1:0]     id;
        logic [4:0]          rd_addr;
        logic [XLEN_MAX-1:0] data;
    } wb_result_t;

endpackage

`default_nettype wire

//--- src/issue_ctrl.sv
// ****************************************
// Issue controller for the four-phase port
// Accepts one instruction when its unit is
// idle and the queue has room, gives it an
// id, pushes it and starts the unit
// ****************************************
`default_nettype none

module issue_ctrl #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    issue_req,
    input  wb_pkg::issue_req_t      issue_data,
    output logic                    issue_ack,
    input  logic                    alu_busy,
    input  logic                    mul_busy,
    input  logic                    iq_full,
    output logic                    iq_push,
    output wb_pkg::iq_entry_t       iq_push_entry,
    output logic                    alu_start,
    output logic                    mul_start,
    output wb_pkg::unit_start_t     start_data
);

    typedef enum logic {
        IDLE,
        ACKED
    } port_state_t;

    port_state_t               state;
    wb_pkg::unit_t             target_unit;
    logic                      target_busy;
    logic                      accept;
    logic [wb_pkg::ID_W-1:0]   next_id;

    // Ids of queued entries must stay unique, so the queue may not outgrow the id space
    if (IQ_DEPTH > (1 << wb_pkg::ID_W)) begin : g_depth_check
        $error("Queue depth exceeds the number of distinct sequence ids");
    end

    // Only multiplies go to the multiplier
    assign target_unit = (issue_data.op == wb_pkg::OP_MUL) ? wb_pkg::UNIT_MUL : wb_pkg::UNIT_ALU;
    assign target_busy = (target_unit == wb_pkg::UNIT_MUL) ? mul_busy : alu_busy;

    // A request is taken once, in IDLE, when nothing holds it back
    assign accept = (state == IDLE) && issue_req && !target_busy && !iq_full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            next_id <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= ACKED;
                        next_id <= next_id + 1'b1;
                    end
                end
                // Wait for the source to drop its request before releasing ack
                ACKED: begin
                    if (!issue_req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign issue_ack = (state == ACKED);

    // Queue push and unit start are captured on the accepting edge
    assign iq_push   = accept;
    assign alu_start = accept && (target_unit == wb_pkg::UNIT_ALU);
    assign mul_start = accept && (target_unit == wb_pkg::UNIT_MUL);

    assign iq_push_entry = '{id: next_id, unit: target_unit, rd_addr: issue_data.rd_addr};
    assign start_data    = '{op: issue_data.op, id: next_id, a: issue_data.a, b: issue_data.b};

endmodule

`default_nettype wire

//--- src/inflight_queue.sv
// ****************************************
// Age-ordered queue of issued instructions
// Position zero is the oldest. Any slot can
// be popped; younger entries shift down and
// a push lands behind the survivors
// ****************************************
`default_nettype none

module inflight_queue #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 push,
    input  wb_pkg::iq_entry_t    push_entry,
    input  logic [IQ_DEPTH-1:0]  pop,
    output logic [IQ_DEPTH-1:0]  valid,
    output wb_pkg::iq_entry_t    entries [IQ_DEPTH],
    output logic                 full
);

    logic [IQ_DEPTH-1:0] valid_shift;
    logic [IQ_DEPTH-1:0] valid_next;
    wb_pkg::iq_entry_t   entries_shift [IQ_DEPTH];
    wb_pkg::iq_entry_t   entries_next [IQ_DEPTH];
    logic                shifting;
    logic                placed;

    // Every slot at or above the popped one takes its younger neighbour
    always_comb begin
        shifting = 1'b0;
        for (int i = 0; i < IQ_DEPTH - 1; i++) begin
            shifting = shifting | pop[i];
            valid_shift[i]   = shifting ? valid[i+1] : valid[i];
            entries_shift[i] = shifting ? entries[i+1] : entries[i];
        end
        shifting = shifting | pop[IQ_DEPTH-1];
        // The top slot has nothing above it to pull in
        valid_shift[IQ_DEPTH-1]   = shifting ? 1'b0 : valid[IQ_DEPTH-1];
        entries_shift[IQ_DEPTH-1] = entries[IQ_DEPTH-1];
    end

    // Valids stay contiguous from zero, so the first free slot is the tail
    always_comb begin
        valid_next   = valid_shift;
        entries_next = entries_shift;
        placed       = 1'b0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (push && !placed && !valid_shift[i]) begin
                valid_next[i]   = 1'b1;
                entries_next[i] = push_entry;
                placed          = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else begin
            valid <= valid_next;
        end
    end

    always_ff @(posedge clk) begin
        entries <= entries_next;
    end

    assign full = &valid;

endmodule

`default_nettype wire

//--- src/alu_unit.sv
// ****************************************
// Single-cycle ALU for add, sub and xor
// Result and done hold until writeback
// gives the accept pulse
// ****************************************
`default_nettype none

module alu_unit #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  wb_pkg::unit_start_t  start_data,
    input  logic                 accept,
    output logic                 busy,
    output logic                 done,
    output logic [XLEN-1:0]      result
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    assign op_a = start_data.a[XLEN-1:0];
    assign op_b = start_data.b[XLEN-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b1;
        end else if (accept) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            case (start_data.op)
                wb_pkg::OP_ADD: result <= op_a + op_b;
                wb_pkg::OP_SUB: result <= op_a - op_b;
                wb_pkg::OP_XOR: result <= op_a ^ op_b;
                default:        result <= '0;
            endcase
        end
    end

    // The result is ready one edge after start, so busy and done cover the same cycles
    assign busy = done;

endmodule

`default_nettype wire

//--- src/mul_unit.sv
// ****************************************
// Three-cycle multiplier, lower product
// Operands are latched, split into two
// partial products, then summed. done and
// the result hold until accept
// ****************************************
`default_nettype none

module mul_unit #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  wb_pkg::unit_start_t  start_data,
    input  logic                 accept,
    output logic                 busy,
    output logic                 done,
    output logic [XLEN-1:0]      result
);

    localparam int HALF = XLEN / 2;

    logic [1:0]      steps_left;
    logic [XLEN-1:0] a_r;
    logic [XLEN-1:0] b_r;
    logic [XLEN-1:0] prod_lo;
    logic [XLEN-1:0] prod_hi;

    // Countdown from start: 2 means operands latched, 1 means partials ready
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            steps_left <= 2'd0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            if (start) begin
                steps_left <= 2'd2;
                busy       <= 1'b1;
            end else if (steps_left != 2'd0) begin
                steps_left <= steps_left - 2'd1;
            end
            if (steps_left == 2'd1) begin
                done <= 1'b1;
            end else if (accept) begin
                done <= 1'b0;
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_r <= start_data.a[XLEN-1:0];
            b_r <= start_data.b[XLEN-1:0];
        end
        // a * b = a * b_lo + (a * b_hi) << HALF, kept to XLEN bits
        if (steps_left == 2'd2) begin
            prod_lo <= a_r * b_r[HALF-1:0];
            prod_hi <= a_r * b_r[XLEN-1:HALF];
        end
        if (steps_left == 2'd1) begin
            result <= prod_lo + (prod_hi << HALF);
        end
    end

endmodule

`default_nettype wire

//--- src/write_back.sv
// ****************************************
// Writeback arbiter for the shared port
// Picks the oldest retirable queue entry,
// pops it, accepts its unit and presents
// the result one cycle later on the write
// port and the completion output
// ****************************************
`default_nettype none

module write_back #(
    parameter int XLEN     = 32,
    parameter int IQ_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 inorder,
    input  logic                 suppress,
    input  logic [IQ_DEPTH-1:0]  iq_valid,
    input  wb_pkg::iq_entry_t    iq_entries [IQ_DEPTH],
    output logic [IQ_DEPTH-1:0]  iq_pop,
    input  logic                 alu_done,
    input  logic                 mul_done,
    input  logic [XLEN-1:0]      alu_result,
    input  logic [XLEN-1:0]      mul_result,
    output logic                 alu_accept,
    output logic                 mul_accept,
    output logic                 rf_we,
    output logic                 complete,
    output wb_pkg::wb_result_t   wb_out
);

    logic                    entry_done;
    logic                    scan_stop;
    logic                    sel_found;
    wb_pkg::iq_entry_t       sel_entry;
    logic [wb_pkg::ID_W-1:0] id_r;
    logic [4:0]              rd_r;
    wb_pkg::unit_t           unit_r;

    // Oldest-first scan. In order mode the oldest valid entry ends the scan
    // whether or not its unit is done, so younger entries wait behind it
    always_comb begin
        iq_pop     = '0;
        sel_found  = 1'b0;
        sel_entry  = iq_entries[0];
        scan_stop  = 1'b0;
        entry_done = 1'b0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!scan_stop && iq_valid[i]) begin
                entry_done = (iq_entries[i].unit == wb_pkg::UNIT_MUL) ? mul_done : alu_done;
                if (entry_done) begin
                    iq_pop[i] = 1'b1;
                    sel_found = 1'b1;
                    sel_entry = iq_entries[i];
                end
                scan_stop = inorder || entry_done;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_accept <= 1'b0;
            mul_accept <= 1'b0;
            complete   <= 1'b0;
            rf_we      <= 1'b0;
        end else begin
            alu_accept <= sel_found && (sel_entry.unit == wb_pkg::UNIT_ALU);
            mul_accept <= sel_found && (sel_entry.unit == wb_pkg::UNIT_MUL);
            complete   <= sel_found;
            // Suppressed or x0 destinations still retire, they just skip the write
            rf_we      <= sel_found && !suppress && (sel_entry.rd_addr != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (sel_found) begin
            id_r   <= sel_entry.id;
            rd_r   <= sel_entry.rd_addr;
            unit_r <= sel_entry.unit;
        end
    end

    // The accepted unit keeps its result through the accept cycle,
    // so data comes straight from the unit named by unit_r
    always_comb begin
        wb_out         = '0;
        wb_out.id      = id_r;
        wb_out.rd_addr = rd_r;
        wb_out.data[XLEN-1:0] = (unit_r == wb_pkg::UNIT_MUL) ? mul_result : alu_result;
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
// ****************************************
// Thirty-two entry register file
// One synchronous write port fed by the
// writeback arbiter, one combinational
// read port. x0 always reads zero
// ****************************************
`default_nettype none

module reg_file #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 we,
    input  wb_pkg::wb_result_t   wdata_in,
    input  logic [4:0]           raddr,
    output logic [XLEN-1:0]      rdata
);

    // No storage for x0
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wdata_in.rd_addr != 5'd0)) begin
            regs[wdata_in.rd_addr] <= wdata_in.data[XLEN-1:0];
        end
    end

    assign rdata = (raddr == 5'd0) ? '0 : regs[raddr];

endmodule

`default_nettype wire

//--- src/wb_top.sv
// ****************************************
// Top of the completion stage
// Sets data width and queue depth and wires
// issue, queue, units, writeback and the
// register file together
// ****************************************
`default_nettype none

module wb_top #(
    parameter int XLEN     = 32,
    parameter int IQ_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 issue_req,
    input  wb_pkg::issue_req_t   issue_data,
    output logic                 issue_ack,
    input  logic                 inorder,
    input  logic                 suppress,
    output logic                 complete,
    output wb_pkg::wb_result_t   wb_out,
    input  logic [4:0]           rf_raddr,
    output logic [XLEN-1:0]      rf_rdata
);

    logic                iq_push;
    wb_pkg::iq_entry_t   iq_push_entry;
    logic [IQ_DEPTH-1:0] iq_pop;
    logic [IQ_DEPTH-1:0] iq_valid;
    wb_pkg::iq_entry_t   iq_entries [IQ_DEPTH];
    logic                iq_full;
    wb_pkg::unit_start_t start_data;
    logic                alu_start;
    logic                alu_busy;
    logic                alu_done;
    logic                alu_accept;
    logic [XLEN-1:0]     alu_result;
    logic                mul_start;
    logic                mul_busy;
    logic                mul_done;
    logic                mul_accept;
    logic [XLEN-1:0]     mul_result;
    logic                rf_we;

    issue_ctrl #(.IQ_DEPTH(IQ_DEPTH)) u_issue_ctrl (
        .clk, .arst_n, .issue_req, .issue_data, .issue_ack,
        .alu_busy, .mul_busy, .iq_full, .iq_push, .iq_push_entry,
        .alu_start, .mul_start, .start_data
    );

    inflight_queue #(.IQ_DEPTH(IQ_DEPTH)) u_inflight_queue (
        .clk, .arst_n, .push(iq_push), .push_entry(iq_push_entry), .pop(iq_pop),
        .valid(iq_valid), .entries(iq_entries), .full(iq_full)
    );

    alu_unit #(.XLEN(XLEN)) u_alu_unit (
        .clk, .arst_n, .start(alu_start), .start_data, .accept(alu_accept),
        .busy(alu_busy), .done(alu_done), .result(alu_result)
    );

    mul_unit #(.XLEN(XLEN)) u_mul_unit (
        .clk, .arst_n, .start(mul_start), .start_data, .accept(mul_accept),
        .busy(mul_busy), .done(mul_done), .result(mul_result)
    );

    write_back #(.XLEN(XLEN), .IQ_DEPTH(IQ_DEPTH)) u_write_back (
        .clk, .arst_n, .inorder, .suppress, .iq_valid, .iq_entries, .iq_pop,
        .alu_done, .mul_done, .alu_result, .mul_result, .alu_accept, .mul_accept,
        .rf_we, .complete, .wb_out
    );

    reg_file #(.XLEN(XLEN)) u_reg_file (
        .clk, .arst_n, .we(rf_we), .wdata_in(wb_out), .raddr(rf_raddr), .rdata(rf_rdata)
    );

endmodule

`default_nettype wire

//--- testbench/wb_checker.sv
// ****************************************
// Completion checker for the testbench
// Keeps the record of outstanding ids,
// compares every completion, keeps model
// registers and reads the register file
// back once the run has drained
// ****************************************
`default_nettype none

module wb_checker #(
    parameter int XLEN = 32
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               issue_ack,
    input  logic               complete,
    input  wb_pkg::wb_result_t wb_out,
    input  logic [XLEN-1:0]    rf_rdata,
    output logic [4:0]         rf_raddr,
    input  logic               rec_valid,
    input  wb_pkg::wb_result_t rec_entry,
    input  logic               rec_inorder,
    input  logic               rec_suppress,
    input  logic               readback_go,
    output logic               readback_done,
    output int                 completed,
    output int                 ack_rises,
    output int                 data_errs,
    output int                 order_errs,
    output int                 rb_errs
);
    timeunit 1ns;
    timeprecision 1ps;

    wb_pkg::wb_result_t exp_res [16];
    int                 exp_seq [16];
    logic [15:0]        pending;
    logic [15:0]        exp_inorder;
    logic [15:0]        exp_suppress;
    logic [XLEN-1:0]    model_regs [32];
    logic               ack_prev;
    int                 next_seq;
    int                 oldest;
    int                 oldest_seq;

    // Outputs are sampled mid-cycle, away from the edge where they change
    always @(negedge clk) begin
        if (!arst_n) begin
            pending    = '0;
            ack_prev   = 1'b0;
            next_seq   = 0;
            completed  = 0;
            ack_rises  = 0;
            data_errs  = 0;
            order_errs = 0;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (issue_ack && !ack_prev) begin
                ack_rises++;
            end
            ack_prev = issue_ack;
            // A record is taken before a completion seen at the same sample
            if (rec_valid) begin
                if (pending[rec_entry.id]) begin
                    $display("Id %0d was issued again while still outstanding", rec_entry.id);
                    order_errs++;
                end
                exp_res[rec_entry.id]      = rec_entry;
                exp_seq[rec_entry.id]      = next_seq;
                exp_inorder[rec_entry.id]  = rec_inorder;
                exp_suppress[rec_entry.id] = rec_suppress;
                pending[rec_entry.id]      = 1'b1;
                next_seq++;
            end
            if (complete) begin
                completed++;
                if (!pending[wb_out.id]) begin
                    $display("Completion for id %0d has no outstanding instruction", wb_out.id);
                    order_errs++;
                end else begin
                    oldest     = -1;
                    oldest_seq = 0;
                    for (int i = 0; i < 16; i++) begin
                        if (pending[i] && (oldest < 0 || exp_seq[i] < oldest_seq)) begin
                            oldest     = i;
                            oldest_seq = exp_seq[i];
                        end
                    end
                    // In order mode only the oldest outstanding id may retire
                    if (exp_inorder[wb_out.id] && oldest != int'(wb_out.id)) begin
                        $display("error wb_out.id expected %h actual %h", oldest, wb_out.id);
                        order_errs++;
                    end
                    if (wb_out.data[XLEN-1:0] !== exp_res[wb_out.id].data[XLEN-1:0]) begin
                        $display("error wb_out.data expected %h actual %h",
                                 exp_res[wb_out.id].data[XLEN-1:0], wb_out.data[XLEN-1:0]);
                        data_errs++;
                    end
                    if (wb_out.rd_addr !== exp_res[wb_out.id].rd_addr) begin
                        $display("error wb_out.rd_addr expected %h actual %h",
                                 exp_res[wb_out.id].rd_addr, wb_out.rd_addr);
                        data_errs++;
                    end
                    // Suppressed results and x0 leave the model registers alone
                    if (!exp_suppress[wb_out.id] && exp_res[wb_out.id].rd_addr != 5'd0) begin
                        model_regs[exp_res[wb_out.id].rd_addr] =
                            exp_res[wb_out.id].data[XLEN-1:0];
                    end
                    pending[wb_out.id] = 1'b0;
                end
            end
        end
    end

    // Final sweep over all registers through the read port
    initial begin
        rf_raddr      = 5'd0;
        readback_done = 1'b0;
        rb_errs       = 0;
        wait (readback_go);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            rf_raddr <= r[4:0];
            @(negedge clk);
            if (rf_rdata !== model_regs[r]) begin
                $display("error rf_rdata x%0d expected %h actual %h", r, model_regs[r], rf_rdata);
                rb_errs++;
            end
        end
        readback_done = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/wb_assertions.sv
// ****************************************
// Concurrent checks bound into the top
// Watches the issue_ctrl handshake and the
// write_back accept and write outputs
// ****************************************
`default_nettype none

module wb_assertions (
    input logic               clk,
    input logic               arst_n,
    input logic               issue_req,
    input logic               issue_ack,
    input logic               rf_we,
    input wb_pkg::wb_result_t wb_out,
    input logic               alu_accept,
    input logic               mul_accept,
    input logic               alu_done,
    input logic               mul_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // The acknowledge may only drop after the request has gone low
    ack_holds: assert property (@(posedge clk) disable iff (!arst_n)
        issue_ack && issue_req |=> issue_ack)
        else $error("issue_ack fell while issue_req was still high");

    // x0 is never a write target
    no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        rf_we |-> wb_out.rd_addr != 5'd0)
        else $error("Register write enabled for register zero");

    // Only one unit owns the write port per cycle
    one_accept: assert property (@(posedge clk) disable iff (!arst_n)
        !(alu_accept && mul_accept))
        else $error("Both units were accepted in the same cycle");

    // A unit is only accepted while it still holds a finished result
    alu_accept_done: assert property (@(posedge clk) disable iff (!arst_n)
        alu_accept |-> alu_done)
        else $error("ALU accepted without a finished result");

    mul_accept_done: assert property (@(posedge clk) disable iff (!arst_n)
        mul_accept |-> mul_done)
        else $error("Multiplier accepted without a finished result");

endmodule

bind wb_top wb_assertions u_wb_assertions (
    .clk, .arst_n, .issue_req, .issue_ack, .rf_we, .wb_out, .alu_accept, .mul_accept,
    .alu_done, .mul_done
);

`default_nettype wire

//--- testbench/tb_wb_top.sv
// ****************************************
// Testbench top for the completion stage
// Drives random and directed instructions
// over the four-phase port in both retire
// modes, with and without suppress, and
// hands each accepted one to the checker
// ****************************************
`default_nettype none

module tb_wb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN       = 32;
    localparam int IQ_DEPTH   = 4;
    localparam int NUM_INSTR  = 200;
    // Worst case of twelve cycles per instruction plus slack for reset and readback
    localparam int MAX_CYCLES = NUM_INSTR * 12 + 100;

    logic               clk;
    logic               arst_n;
    logic               issue_req;
    wb_pkg::issue_req_t issue_data;
    logic               issue_ack;
    logic               inorder;
    logic               suppress;
    logic               complete;
    wb_pkg::wb_result_t wb_out;
    logic [4:0]         rf_raddr;
    logic [XLEN-1:0]    rf_rdata;
    logic               rec_valid;
    wb_pkg::wb_result_t rec_entry;
    logic               rec_inorder;
    logic               rec_suppress;
    logic               readback_go;
    logic               readback_done;
    int                 completed;
    int                 ack_rises;
    int                 data_errs;
    int                 order_errs;
    int                 rb_errs;
    int                 tb_errs;
    int                 issued;
    int                 cycles;
    logic [3:0]         next_id;
    integer             seed;

    wb_top #(.XLEN(XLEN), .IQ_DEPTH(IQ_DEPTH)) dut (
        .clk, .arst_n, .issue_req, .issue_data, .issue_ack, .inorder, .suppress,
        .complete, .wb_out, .rf_raddr, .rf_rdata
    );

    wb_checker #(.XLEN(XLEN)) u_checker (
        .clk, .arst_n, .issue_ack, .complete, .wb_out, .rf_rdata, .rf_raddr,
        .rec_valid, .rec_entry, .rec_inorder, .rec_suppress, .readback_go,
        .readback_done, .completed, .ack_rises, .data_errs, .order_errs, .rb_errs
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Hard stop in case a handshake or a drain never finishes
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // Expected value of an instruction, taken from the opcode definitions
    function automatic logic [XLEN-1:0] ref_result(input wb_pkg::op_t op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        case (op)
            wb_pkg::OP_ADD: return a + b;
            wb_pkg::OP_SUB: return a - b;
            wb_pkg::OP_XOR: return a ^ b;
            default:        return a * b;
        endcase
    endfunction

    // One full four-phase transfer; called just after a rising edge
    task automatic issue_one(input wb_pkg::op_t op, input logic [4:0] rd,
                             input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        issue_req  <= 1'b1;
        issue_data <= '{op: op, rd_addr: rd, a: a, b: b};
        do @(posedge clk); while (!issue_ack);
        // Ids are handed out in issue order starting from zero
        rec_valid    <= 1'b1;
        rec_entry    <= '{id: next_id, rd_addr: rd, data: ref_result(op, a, b)};
        rec_inorder  <= inorder;
        rec_suppress <= suppress;
        issue_req    <= 1'b0;
        @(posedge clk);
        rec_valid <= 1'b0;
        while (issue_ack) @(posedge clk);
        next_id = next_id + 4'd1;
        issued++;
    endtask

    // Waits a bounded time for every issued instruction to retire
    task automatic drain();
        int waited;
        waited = 0;
        while (completed < issued && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (completed < issued) begin
            $display("%0d issued instructions never completed", issued - completed);
            tb_errs++;
        end
    endtask

    task automatic run_random(input logic mode_inorder, input logic mode_suppress,
                              input int count);
        logic [31:0] r;
        inorder  <= mode_inorder;
        suppress <= mode_suppress;
        @(posedge clk);
        for (int n = 0; n < count; n++) begin
            r = $random(seed);
            issue_one(wb_pkg::op_t'(r[1:0]), r[6:2], $random(seed), $random(seed));
        end
        drain();
    endtask

    // A multiply followed straight away by an ALU op, retired oldest-done first
    task automatic run_pairs(input int count);
        logic [31:0] r;
        inorder  <= 1'b0;
        suppress <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < count; n++) begin
            r = $random(seed);
            issue_one(wb_pkg::OP_MUL, r[4:0], $random(seed), $random(seed));
            issue_one(wb_pkg::op_t'(r[9:8] % 3), r[14:10], $random(seed), $random(seed));
        end
        drain();
    endtask

    initial begin
        seed         = 32'h3034d7ae;
        arst_n       = 1'b0;
        issue_req    = 1'b0;
        issue_data   = '0;
        inorder      = 1'b1;
        suppress     = 1'b0;
        rec_valid    = 1'b0;
        rec_entry    = '0;
        rec_inorder  = 1'b0;
        rec_suppress = 1'b0;
        readback_go  = 1'b0;
        tb_errs      = 0;
        issued       = 0;
        cycles       = 0;
        next_id      = 4'd0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        run_random(1'b1, 1'b0, 50);
        run_random(1'b0, 1'b0, 50);
        run_pairs(10);
        run_random(1'b0, 1'b1, 40);
        run_random(1'b1, 1'b1, 40);
        readback_go <= 1'b1;
        while (!readback_done) @(posedge clk);
        // Each request must have raised the acknowledge exactly once
        if (ack_rises != issued) begin
            $display("%0d acknowledges were seen for %0d requests", ack_rises, issued);
            tb_errs++;
        end
        $display("Errors: data %0d, order %0d, readback %0d, other %0d",
                 data_errs, order_errs, rb_errs, tb_errs);
        if (data_errs + order_errs + rb_errs + tb_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
src/wb_pkg.sv
src/issue_ctrl.sv
src/inflight_queue.sv
src/alu_unit.sv
src/mul_unit.sv
src/write_back.sv
src/reg_file.sv
src/wb_top.sv
testbench/wb_checker.sv
testbench/wb_assertions.sv
testbench/tb_wb_top.sv

//--- Bender.yml
package:
  name: wb_core

sources:
  - files:
      - src/wb_pkg.sv
      - src/issue_ctrl.sv
      - src/inflight_queue.sv
      - src/alu_unit.sv
      - src/mul_unit.sv
      - src/write_back.sv
      - src/reg_file.sv
      - src/wb_top.sv
  - target: test
    files:
      - testbench/wb_checker.sv
      - testbench/wb_assertions.sv
      - testbench/tb_wb_top.sv
